//--- rv_pkg.sv
package rv_pkg;

  typedef logic [31:0] word_t;      // Data, address or instruction word
  typedef logic [4:0]  reg_addr_t;  // Register index
  typedef logic [6:0]  opcode_t;    // Major opcode
  typedef logic [2:0]  funct3_t;    // Minor opcode
  typedef logic [3:0]  alu_op_t;    // ALU operation select
  typedef logic [3:0]  byte_en_t;   // Per-byte write enable toward dmem

  localparam int    NUM_REGS = 32;
  localparam word_t RESET_PC = 32'h0000_0000;

  // RV32I major opcodes
  localparam opcode_t OP_LOAD     = 7'b00_000_11;
  localparam opcode_t OP_STORE    = 7'b01_000_11;
  localparam opcode_t OP_BRANCH   = 7'b11_000_11;
  localparam opcode_t OP_JALR     = 7'b11_001_11;
  localparam opcode_t OP_MISC_MEM = 7'b00_011_11;
  localparam opcode_t OP_JAL      = 7'b11_011_11;
  localparam opcode_t OP_OP_IMM   = 7'b00_100_11;
  localparam opcode_t OP_OP       = 7'b01_100_11;
  localparam opcode_t OP_SYSTEM   = 7'b11_100_11;
  localparam opcode_t OP_AUIPC    = 7'b00_101_11;
  localparam opcode_t OP_LUI      = 7'b01_101_11;

  // ALU operations
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;  // LUI

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // Load and store widths
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

endpackage

//--- rv_decode.sv
module rv_decode (
  input  rv_pkg::word_t     insn,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::funct3_t   funct3,
  output rv_pkg::word_t     imm,
  output rv_pkg::alu_op_t   alu_op,
  output logic              alu_src_imm,
  output logic              reg_write,
  output logic              is_load,
  output logic              is_store,
  output logic              is_branch,
  output logic              is_jal,
  output logic              is_jalr,
  output logic              is_lui,
  output logic              is_auipc,
  output logic              is_system
);
  import rv_pkg::*;

  opcode_t opcode;
  logic    is_op;
  logic    is_op_imm;
  logic    alt;  // funct7 bit 30 selects SUB / SRA
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_j;
  word_t   imm_u;

  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign alt    = insn[30];

  // Immediate formats, all sign-extended from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign is_load   = (opcode == OP_LOAD);
  assign is_store  = (opcode == OP_STORE);
  assign is_branch = (opcode == OP_BRANCH);
  assign is_jal    = (opcode == OP_JAL);
  assign is_jalr   = (opcode == OP_JALR);
  assign is_lui    = (opcode == OP_LUI);
  assign is_auipc  = (opcode == OP_AUIPC);
  assign is_system = (opcode == OP_SYSTEM);  // ECALL halts
  assign is_op     = (opcode == OP_OP);
  assign is_op_imm = (opcode == OP_OP_IMM);

  always_comb begin
    if (is_store) imm = imm_s;
    else if (is_branch) imm = imm_b;
    else if (is_jal) imm = imm_j;
    else if (is_lui || is_auipc) imm = imm_u;
    else imm = imm_i;
  end

  // Only register-register ops and branches take rs2 as operand b
  assign alu_src_imm = !(is_op || is_branch);

  always_comb begin
    alu_op = ALU_ADD;  // Address and JALR target sums
    if (is_lui) begin
      alu_op = ALU_PASS_B;
    end else if (is_op || is_op_imm) begin
      case (funct3)
        3'b000:  alu_op = (is_op && alt) ? ALU_SUB : ALU_ADD;
        3'b001:  alu_op = ALU_SLL;
        3'b010:  alu_op = ALU_SLT;
        3'b011:  alu_op = ALU_SLTU;
        3'b100:  alu_op = ALU_XOR;
        3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;  // Same bit for SRAI
        3'b110:  alu_op = ALU_OR;
        default: alu_op = ALU_AND;
      endcase
    end
  end

  // Stores, branches, FENCE, ECALL and unknown opcodes fall through to zero
  always_comb begin
    reg_write = is_lui || is_auipc || is_jal || is_jalr || is_load || is_op || is_op_imm;
    if (rd == '0) begin
      reg_write = 1'b0;
    end
  end

endmodule

//--- rv_regfile.sv
module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  rv_pkg::word_t     rd_data,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);
  import rv_pkg::*;

  word_t regs [1:NUM_REGS-1];  // x0 is not stored

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // Combinational reads, write shows up next cycle
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // x0 reads zero on both ports, including after a write aimed at it
  a_x0_zero: assert property (
    @(posedge clk) disable iff (rst)
    (rs1 == '0 |-> rs1_data == '0) and (rs2 == '0 |-> rs2_data == '0)
  ) else $error("x0 read returned a nonzero value");

endmodule

//--- rv_alu.sv
module rv_alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_t alu_op,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::funct3_t funct3,
  output rv_pkg::word_t   result,
  output logic            branch_taken
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       br_lt_signed;
  logic       br_lt_unsigned;
  logic       br_eq;

  assign shamt = b[4:0];  // Only the low 5 bits shift

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {31'b0, lt_signed};
      ALU_SLTU:   result = {31'b0, lt_unsigned};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt;  // Sign bit fills from the left
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // Branch compare works on the register values
  // The core only looks at it for branches
  assign br_eq          = (rs1_data == rs2_data);
  assign br_lt_signed   = $signed(rs1_data) < $signed(rs2_data);
  assign br_lt_unsigned = rs1_data < rs2_data;

  always_comb begin
    case (funct3)
      F3_BEQ:  branch_taken = br_eq;
      F3_BNE:  branch_taken = !br_eq;
      F3_BLT:  branch_taken = br_lt_signed;
      F3_BGE:  branch_taken = !br_lt_signed;
      F3_BLTU: branch_taken = br_lt_unsigned;
      F3_BGEU: branch_taken = !br_lt_unsigned;
      default: branch_taken = 1'b0;  // 010 and 011 are not branches
    endcase
  end

endmodule

//--- rv_lsu.sv
module rv_lsu (
  input  rv_pkg::word_t    addr,
  input  rv_pkg::word_t    store_src,
  input  rv_pkg::funct3_t  funct3,
  input  logic             is_load,
  input  logic             is_store,
  input  rv_pkg::word_t    load_data_from_dmem,
  output rv_pkg::word_t    addr_to_dmem,
  output rv_pkg::word_t    store_data_to_dmem,
  output rv_pkg::word_t    load_result,
  output rv_pkg::byte_en_t store_we_to_dmem
);
  import rv_pkg::*;

  logic [1:0]  offset;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  byte_en_t    lane_en;

  assign offset       = addr[1:0];
  assign addr_to_dmem = {addr[31:2], 2'b00};  // Memory is word addressed

  // Store data replicated so every lane sees the value
  always_comb begin
    case (funct3)
      F3_B:    store_data_to_dmem = {4{store_src[7:0]}};
      F3_H:    store_data_to_dmem = {2{store_src[15:0]}};
      default: store_data_to_dmem = store_src;
    endcase
  end

  always_comb begin
    case (funct3)
      F3_B:    lane_en = byte_en_t'(4'b0001 << offset);
      F3_H:    lane_en = offset[1] ? 4'b1100 : 4'b0011;
      F3_W:    lane_en = 4'b1111;
      default: lane_en = 4'b0000;
    endcase
  end

  assign store_we_to_dmem = is_store ? lane_en : 4'b0000;

  // Pick the addressed byte / halfword out of the loaded word
  always_comb begin
    case (offset)
      2'd0:    ld_byte = load_data_from_dmem[7:0];
      2'd1:    ld_byte = load_data_from_dmem[15:8];
      2'd2:    ld_byte = load_data_from_dmem[23:16];
      default: ld_byte = load_data_from_dmem[31:24];
    endcase
  end

  assign ld_half = offset[1] ? load_data_from_dmem[31:16] : load_data_from_dmem[15:0];

  always_comb begin
    load_result = '0;
    if (is_load) begin
      case (funct3)
        F3_B:    load_result = {{24{ld_byte[7]}}, ld_byte};
        F3_BU:   load_result = {24'b0, ld_byte};
        F3_H:    load_result = {{16{ld_half[15]}}, ld_half};
        F3_HU:   load_result = {16'b0, ld_half};
        default: load_result = load_data_from_dmem;  // LW
      endcase
    end
  end

  // No memory write may leak out of a non-store instruction
  a_we_only_on_store: assert final (is_store || store_we_to_dmem == '0)
    else $error("store_we_to_dmem active without a store");

endmodule

//--- rv_core.sv
module rv_core (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    insn_from_imem,
  input  rv_pkg::word_t    load_data_from_dmem,
  output rv_pkg::word_t    pc_to_imem,
  output rv_pkg::word_t    addr_to_dmem,
  output rv_pkg::word_t    store_data_to_dmem,
  output rv_pkg::byte_en_t store_we_to_dmem,
  output logic             halt
);
  import rv_pkg::*;

  word_t     pc_q;
  word_t     pc_next;
  word_t     pc_plus4;
  word_t     pc_plus_imm;  // Branch / JAL target, AUIPC value
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  funct3_t   funct3;
  word_t     imm;
  alu_op_t   alu_op;
  logic      alu_src_imm;
  logic      reg_write;
  logic      is_load;
  logic      is_store;
  logic      is_branch;
  logic      is_jal;
  logic      is_jalr;
  logic      is_auipc;
  logic      is_system;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_b;
  word_t     alu_result;
  logic      branch_taken;
  word_t     load_result;
  word_t     wb_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;  // Keeps running past ECALL
    end
  end

  assign pc_to_imem  = pc_q;
  assign pc_plus4    = pc_q + 32'd4;
  assign pc_plus_imm = pc_q + imm;

  rv_decode u_decode (
    .insn        (insn_from_imem),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (rd),
    .funct3      (funct3),
    .imm         (imm),
    .alu_op      (alu_op),
    .alu_src_imm (alu_src_imm),
    .reg_write   (reg_write),
    .is_load     (is_load),
    .is_store    (is_store),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .is_lui      (),            // LUI goes through the ALU pass-through
    .is_auipc    (is_auipc),
    .is_system   (is_system)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (reg_write),
    .rd       (rd),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_b = alu_src_imm ? imm : rs2_data;

  rv_alu u_alu (
    .a            (rs1_data),
    .b            (alu_b),
    .alu_op       (alu_op),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .funct3       (funct3),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  rv_lsu u_lsu (
    .addr                (alu_result),  // rs1 + imm for loads and stores
    .store_src           (rs2_data),
    .funct3              (funct3),
    .is_load             (is_load),
    .is_store            (is_store),
    .load_data_from_dmem (load_data_from_dmem),
    .addr_to_dmem        (addr_to_dmem),
    .store_data_to_dmem  (store_data_to_dmem),
    .load_result         (load_result),
    .store_we_to_dmem    (store_we_to_dmem)
  );

  always_comb begin
    if (is_jalr) pc_next = {alu_result[31:1], 1'b0};
    else if (is_jal || (is_branch && branch_taken)) pc_next = pc_plus_imm;
    else pc_next = pc_plus4;
  end

  always_comb begin
    if (is_load) wb_data = load_result;
    else if (is_jal || is_jalr) wb_data = pc_plus4;  // Link address
    else if (is_auipc) wb_data = pc_plus_imm;
    else wb_data = alu_result;
  end

  assign halt = is_system;

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00
  ) else $error("PC not word aligned: %h", pc_q);

endmodule

//--- tb_rv_core.sv
module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam int    CLK_PERIOD_NS   = 20;
  localparam int    RESET_CYCLES    = 3;
  localparam int    WATCHDOG_MARGIN = 10;  // Spare cycles past the trace length
  localparam string TRACE_FILE      = "rv_core_trace.txt";
  localparam word_t NOP             = 32'h0000_0013;  // ADDI x0, x0, 0

  logic     clk;
  logic     rst;
  word_t    insn_from_imem;
  word_t    load_data_from_dmem;
  word_t    pc_to_imem;
  word_t    addr_to_dmem;
  word_t    store_data_to_dmem;
  byte_en_t store_we_to_dmem;
  logic     halt;

  // One entry per trace cycle
  word_t    insn_q[$];
  word_t    load_q[$];
  word_t    exp_pc_q[$];
  word_t    exp_addr_q[$];
  word_t    exp_data_q[$];
  byte_en_t exp_we_q[$];
  logic     exp_halt_q[$];
  int       num_lines = 0;

  rv_core uut (
    .clk                 (clk),
    .rst                 (rst),
    .insn_from_imem      (insn_from_imem),
    .load_data_from_dmem (load_data_from_dmem),
    .pc_to_imem          (pc_to_imem),
    .addr_to_dmem        (addr_to_dmem),
    .store_data_to_dmem  (store_data_to_dmem),
    .store_we_to_dmem    (store_we_to_dmem),
    .halt                (halt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  // Comment and blank lines give fewer than 7 fields and are skipped
  task automatic load_trace();
    int          fd;
    int          got;
    int          fields;
    string       line;
    word_t       f_insn;
    word_t       f_load;
    word_t       f_pc;
    word_t       f_addr;
    word_t       f_data;
    logic [31:0] f_we;
    logic [31:0] f_halt;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open trace file %s", TRACE_FILE);
      $display("SIMULATION FAILED");
      $fatal(1);
    end else begin
      while (!$feof(fd)) begin
        got = $fgets(line, fd);
        if (got > 0) begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h",
                           f_insn, f_load, f_pc, f_addr, f_data, f_we, f_halt);
          if (fields == 7) begin
            insn_q.push_back(f_insn);
            load_q.push_back(f_load);
            exp_pc_q.push_back(f_pc);
            exp_addr_q.push_back(f_addr);
            exp_data_q.push_back(f_data);
            exp_we_q.push_back(f_we[3:0]);
            exp_halt_q.push_back(f_halt[0]);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic compare_output(input string name, input logic [31:0] expected,
                                input logic [31:0] actual, input int line_no);
    assert (actual === expected)
    else begin
      $display("FAILED %s: expected 0x%h, got 0x%h (trace cycle %0d)",
               name, expected, actual, line_no);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  initial begin
    wait (num_lines > 0);
    #((num_lines + RESET_CYCLES + WATCHDOG_MARGIN) * CLK_PERIOD_NS);
    $display("Watchdog expired before the trace reached its ECALL cycle");
    $display("SIMULATION FAILED");
    $fatal(1);
  end

  initial begin
    int   i;
    logic saw_halt;
    logic is_load_insn;
    rst                 = 1'b1;
    insn_from_imem      = NOP;  // Keeps halt and store enables quiet in reset
    load_data_from_dmem = '0;
    saw_halt            = 1'b0;
    load_trace();
    num_lines = insn_q.size();
    if (num_lines == 0) begin
      $display("Trace file %s holds no cycles", TRACE_FILE);
      $display("SIMULATION FAILED");
      $fatal(1);
    end else begin
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;  // PC 0 shows from this edge on
      i = 0;
      while (i < num_lines && !saw_halt) begin
        insn_from_imem      <= insn_q[i];
        load_data_from_dmem <= load_q[i];
        @(negedge clk);
        is_load_insn = (insn_q[i][6:0] == 7'b000_0011);
        compare_output("pc_to_imem", exp_pc_q[i], pc_to_imem, i);
        compare_output("store_we_to_dmem", {28'b0, exp_we_q[i]}, {28'b0, store_we_to_dmem}, i);
        compare_output("halt", {31'b0, exp_halt_q[i]}, {31'b0, halt}, i);
        if (exp_we_q[i] != '0 || is_load_insn) begin
          compare_output("addr_to_dmem", exp_addr_q[i], addr_to_dmem, i);
        end
        if (exp_we_q[i] != '0) begin  // Data bus only matters on stores
          compare_output("store_data_to_dmem", exp_data_q[i], store_data_to_dmem, i);
        end
        saw_halt = exp_halt_q[i];
        i++;
        @(posedge clk);
      end
      if (saw_halt) begin
        $display("SIMULATION PASSED");
        $finish;
      end else begin
        $display("Trace ended without an ECALL cycle");
        $display("SIMULATION FAILED");
        $fatal(1);
      end
    end
  end

endmodule

//--- rv_core_trace.txt
// insn load_data exp_pc exp_addr exp_store_data exp_store_we exp_halt, one cycle per line, hex
// exp_addr is checked on loads and stores, exp_store_data on stores only
123450B7 00000000 00000000 00000000 00000000 0 0  // lui   x1, 0x12345
67808093 00000000 00000004 00000000 00000000 0 0  // addi  x1, x1, 0x678
10102023 00000000 00000008 00000100 12345678 F 0  // sw    x1, 0x100(x0)
FFB00113 00000000 0000000C 00000000 00000000 0 0  // addi  x2, x0, -5
402081B3 00000000 00000010 00000000 00000000 0 0  // sub   x3, x1, x2
40115213 00000000 00000014 00000000 00000000 0 0  // srai  x4, x2, 1
10402423 00000000 00000018 00000108 FFFFFFFD F 0  // sw    x4, 0x108(x0)
01C15293 00000000 0000001C 00000000 00000000 0 0  // srli  x5, x2, 28
00529333 00000000 00000020 00000000 00000000 0 0  // sll   x6, x5, x5
005123B3 00000000 00000024 00000000 00000000 0 0  // slt   x7, x2, x5
00513433 00000000 00000028 00000000 00000000 0 0  // sltu  x8, x2, x5
007344B3 00000000 0000002C 00000000 00000000 0 0  // xor   x9, x6, x7
0014E533 00000000 00000030 00000000 00000000 0 0  // or    x10, x9, x1
008575B3 00000000 00000034 00000000 00000000 0 0  // and   x11, x10, x8
10A02623 00000000 00000038 0000010C 1237D679 F 0  // sw    x10, 0x10c(x0)
10B02823 00000000 0000003C 00000110 00000000 F 0  // sw    x11, 0x110(x0)
121000A3 00000000 00000040 00000120 78787878 2 0  // sb    x1, 0x121(x0)
12301123 00000000 00000044 00000120 567D567D C 0  // sh    x3, 0x122(x0)
13100603 1122F344 00000048 00000130 00000000 0 0  // lb    x12, 0x131(x0)
13304683 9A000000 0000004C 00000130 00000000 0 0  // lbu   x13, 0x133(x0)
13601703 80017FFF 00000050 00000134 00000000 0 0  // lh    x14, 0x136(x0)
13405783 1234F00D 00000054 00000134 00000000 0 0  // lhu   x15, 0x134(x0)
14C02023 00000000 00000058 00000140 FFFFFFF3 F 0  // sw    x12, 0x140(x0)
14D02223 00000000 0000005C 00000144 0000009A F 0  // sw    x13, 0x144(x0)
14E02423 00000000 00000060 00000148 FFFF8001 F 0  // sw    x14, 0x148(x0)
14F02623 00000000 00000064 0000014C 0000F00D F 0  // sw    x15, 0x14c(x0)
05500013 00000000 00000068 00000000 00000000 0 0  // addi  x0, x0, 0x55
14002823 00000000 0000006C 00000150 00000000 F 0  // sw    x0, 0x150(x0)
00108463 00000000 00000070 00000000 00000000 0 0  // beq   x1, x1, +8 taken
0020C463 00000000 00000078 00000000 00000000 0 0  // blt   x1, x2, +8 not taken
00117663 00000000 0000007C 00000000 00000000 0 0  // bgeu  x2, x1, +12 taken
0100086F 00000000 00000088 00000000 00000000 0 0  // jal   x16, +16
075808E7 00000000 00000098 00000000 00000000 0 0  // jalr  x17, 0x75(x16)
15002A23 00000000 00000100 00000154 0000008C F 0  // sw    x16, 0x154(x0)
15102C23 00000000 00000104 00000158 0000009C F 0  // sw    x17, 0x158(x0)
00002917 00000000 00000108 00000000 00000000 0 0  // auipc x18, 0x2
15202E23 00000000 0000010C 0000015C 00002108 F 0  // sw    x18, 0x15c(x0)
0FF0000F 00000000 00000110 00000000 00000000 0 0  // fence
00000073 00000000 00000114 00000000 00000000 0 1  // ecall

//--- rv_core.f
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv
